//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_exec_core -f compile.f
	./obj_dir/Vtb_exec_core > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
exec_pkg.sv
reg_file.sv
issue_reg.sv
operand_bypass.sv
int_alu.sv
mul_unit.sv
result_pipe.sv
exec_control.sv
exec_core.sv
tb_clock_gen.sv
exec_core_assertions.sv
tb_exec_core.sv

//--- exec_control.sv
module exec_control (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 i_valid,
    input  exec_pkg::uop_t       i_uop,
    input  logic                 i_stall,
    input  logic                 i_ex1_ready,
    input  logic                 i_mul_idle,
    input  logic                 i_taken,
    input  exec_pkg::xlen_t      i_target,
    output logic                 o_ready,
    output logic                 o_issue,
    output exec_pkg::func_unit_e o_unit,
    output logic                 o_mul_start,
    output exec_pkg::redirect_t  o_redirect
);
    import exec_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    xlen_t       exp_pc_q;
    xlen_t       exp_pc_d;
    logic        is_mul;
    logic        handshake;
    logic        pc_match;

    assign is_mul = i_uop.op == OP_MUL;

    // A multiply also waits for the previous one to leave the unit
    assign o_ready   = !i_stall && i_ex1_ready && !(i_valid && is_mul && !i_mul_idle);
    assign handshake = i_valid && o_ready;
    assign pc_match  = i_uop.pc == exp_pc_q;

    // Micro-ops off the expected path are consumed and dropped
    assign o_issue     = handshake && pc_match;
    assign o_unit      = is_mul ? FU_MUL : FU_ALU;
    assign o_mul_start = o_issue && is_mul;

    // Only the first wrong-path micro-op sends the front end back
    assign o_redirect = '{valid: handshake && !pc_match && state_q == ST_NORMAL,
                          pc: exp_pc_q};

    always_comb begin
        state_d  = state_q;
        exp_pc_d = exp_pc_q;
        if (handshake) begin
            state_d = pc_match ? ST_NORMAL : ST_MISPREDICT;
        end
        if (o_issue) begin
            exp_pc_d = i_taken ? i_target : i_uop.pc + INSN_BYTES;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_NORMAL;
            exp_pc_q <= RESET_PC;
        end else begin
            state_q  <= state_d;
            exp_pc_q <= exp_pc_d;
        end
    end

endmodule

//--- exec_core.sv
module exec_core (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                i_uop_valid,
    input  exec_pkg::uop_t      i_uop,
    output logic                o_uop_ready,
    output exec_pkg::redirect_t o_redirect,
    output exec_pkg::commit_t   o_commit
);
    import exec_pkg::*;

    // Issue slot and register read
    logic      slot_valid;
    logic      slot_ready;
    uop_t      slot_uop;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rf_rs1;
    xlen_t     rf_rs2;

    // Operands after forwarding
    xlen_t      rs1;
    xlen_t      rs2;
    logic       stall;
    stage_fwd_t ex1_fwd;
    stage_fwd_t ex2_fwd;
    logic       ex1_ready;

    // Functional units
    xlen_t alu_result;
    logic  taken;
    xlen_t target;
    logic  mul_idle;
    logic  mul_valid;
    xlen_t mul_data;

    // Issue and write back
    logic       issue;
    func_unit_e unit;
    logic       mul_start;
    logic       wr_en;
    reg_addr_t  wr_addr;
    xlen_t      wr_data;

    ////////////////////
    // Issue
    ////////////////////

    issue_reg u_issue_reg (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .i_valid    (i_uop_valid),
        .i_uop      (i_uop),
        .i_ready    (slot_ready),
        .o_ready    (o_uop_ready),
        .o_valid    (slot_valid),
        .o_uop      (slot_uop),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_rs1_data (rf_rs1),
        .o_rs2_data (rf_rs2)
    );

    operand_bypass u_operand_bypass (
        .i_uop      (slot_uop),
        .i_rs1_data (rf_rs1),
        .i_rs2_data (rf_rs2),
        .i_ex1      (ex1_fwd),
        .i_ex2      (ex2_fwd),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_stall    (stall)
    );

    exec_control u_exec_control (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .i_valid     (slot_valid),
        .i_uop       (slot_uop),
        .i_stall     (stall),
        .i_ex1_ready (ex1_ready),
        .i_mul_idle  (mul_idle),
        .i_taken     (taken),
        .i_target    (target),
        .o_ready     (slot_ready),
        .o_issue     (issue),
        .o_unit      (unit),
        .o_mul_start (mul_start),
        .o_redirect  (o_redirect)
    );

    ////////////////////
    // Execute
    ////////////////////

    int_alu u_int_alu (
        .i_uop    (slot_uop),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .o_result (alu_result),
        .o_taken  (taken),
        .o_target (target)
    );

    mul_unit u_mul_unit (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .i_start (mul_start),
        .i_a     (rs1),
        .i_b     (rs2),
        .o_idle  (mul_idle),
        .o_valid (mul_valid),
        .o_data  (mul_data)
    );

    result_pipe u_result_pipe (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .i_issue     (issue),
        .i_unit      (unit),
        .i_rd        (slot_uop.rd),
        .i_pc        (slot_uop.pc),
        .i_alu_data  (alu_result),
        .i_mul_valid (mul_valid),
        .i_mul_data  (mul_data),
        .o_ex1_ready (ex1_ready),
        .o_ex1       (ex1_fwd),
        .o_ex2       (ex2_fwd),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_commit    (o_commit)
    );

endmodule

//--- exec_core_assertions.sv
module exec_core_assertions (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  i_handshake,
    input exec_pkg::ctrl_state_e i_state,
    input logic                  i_redirect_valid,
    input exec_pkg::xlen_t       i_redirect_pc,
    input logic                  i_issue,
    input exec_pkg::xlen_t       i_pc
);
    import exec_pkg::*;

    // Wrong-path window as seen on the outputs, and the pc that ends it
    logic  dropping_q;
    xlen_t recover_pc_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dropping_q   <= 1'b0;
            recover_pc_q <= RESET_PC;
        end else if (i_redirect_valid) begin
            dropping_q   <= 1'b1;
            recover_pc_q <= i_redirect_pc;
        end else if (i_issue) begin
            dropping_q <= 1'b0;
        end
    end

    // Redirect only from a consumed micro-op while on the correct path
    redirect_on_handshake: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        i_redirect_valid |-> (i_handshake && !dropping_q)
    ) else $error("redirect without a slot handshake in ST_NORMAL");

    redirect_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        i_redirect_valid |=> !i_redirect_valid
    ) else $error("redirect held for more than one cycle");

    // Leaving the mispredict state needs the pc sent with the redirect
    recover_on_expected_pc: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (i_issue && i_state == ST_MISPREDICT) |-> (i_pc == recover_pc_q)
    ) else $error("issue in ST_MISPREDICT with a pc other than the redirect target");

endmodule

//--- exec_pkg.sv
package exec_pkg;

    // Datapath geometry
    localparam int unsigned XLEN = 32;
    localparam int unsigned NUM_REGS = 32;
    localparam int unsigned REG_AW = 5;
    localparam int unsigned INSN_BYTES = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // First PC expected out of reset
    localparam xlen_t RESET_PC = '0;

    // Micro-op codes as delivered by the external decoder
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL,
        OP_MUL
    } uop_op_e;

    // Where a result stage takes its data from
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

    typedef enum logic {
        ST_NORMAL,
        ST_MISPREDICT
    } ctrl_state_e;

    typedef struct packed {
        xlen_t     pc;
        uop_op_e   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        xlen_t     imm;
    } uop_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
        xlen_t     pc;
    } commit_t;

    // Forwarding view of one result stage
    typedef struct packed {
        logic      pending;
        reg_addr_t rd;
        logic      data_valid;
        xlen_t     data;
    } stage_fwd_t;

endpackage

//--- int_alu.sv
module int_alu (
    input  exec_pkg::uop_t  i_uop,
    input  exec_pkg::xlen_t i_rs1,
    input  exec_pkg::xlen_t i_rs2,
    output exec_pkg::xlen_t o_result,
    output logic            o_taken,
    output exec_pkg::xlen_t o_target
);
    import exec_pkg::*;

    xlen_t      op_b;
    xlen_t      sum;
    xlen_t      diff;
    xlen_t      link;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       br_eq;
    logic       br_lt;

    assign op_b  = i_uop.use_imm ? i_uop.imm : i_rs2;
    assign sum   = i_rs1 + op_b;
    assign diff  = i_rs1 - op_b;
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(i_rs1) < $signed(op_b);
    assign lt_u  = i_rs1 < op_b;

    // Branches compare rs1 with rs2 and use the immediate as offset
    assign br_eq = i_rs1 == i_rs2;
    assign br_lt = $signed(i_rs1) < $signed(i_rs2);

    assign link     = i_uop.pc + INSN_BYTES;
    assign o_target = i_uop.pc + i_uop.imm;

    always_comb begin
        case (i_uop.op)
            OP_ADD:  o_result = sum;
            OP_SUB:  o_result = diff;
            OP_AND:  o_result = i_rs1 & op_b;
            OP_OR:   o_result = i_rs1 | op_b;
            OP_XOR:  o_result = i_rs1 ^ op_b;
            OP_SLL:  o_result = i_rs1 << shamt;
            OP_SRL:  o_result = i_rs1 >> shamt;
            OP_SRA:  o_result = xlen_t'($signed(i_rs1) >>> shamt);
            OP_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
            // Control flow writes the return address
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL: o_result = link;
            default: o_result = sum;
        endcase
    end

    always_comb begin
        case (i_uop.op)
            OP_BEQ:  o_taken = br_eq;
            OP_BNE:  o_taken = !br_eq;
            OP_BLT:  o_taken = br_lt;
            OP_BGE:  o_taken = !br_lt;
            OP_JAL:  o_taken = 1'b1;
            default: o_taken = 1'b0;
        endcase
    end

endmodule

//--- issue_reg.sv
module issue_reg (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                i_valid,
    input  exec_pkg::uop_t      i_uop,
    input  logic                i_ready,
    output logic                o_ready,
    output logic                o_valid,
    output exec_pkg::uop_t      o_uop,
    output exec_pkg::reg_addr_t o_rs1_addr,
    output exec_pkg::reg_addr_t o_rs2_addr
);

    // Slot shares its ready with the issue stage
    // A new micro-op enters when the held one leaves or the slot is empty
    assign o_ready = i_ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            o_valid    <= 1'b0;
            o_uop      <= '0;
            o_rs1_addr <= '0;
            o_rs2_addr <= '0;
        end else if (i_valid && i_ready) begin
            o_valid    <= 1'b1;
            o_uop      <= i_uop;
            // Register file reads these in the following cycle
            o_rs1_addr <= i_uop.rs1;
            o_rs2_addr <= i_uop.rs2;
        end else if (o_valid && i_ready) begin
            o_valid <= 1'b0;
        end
    end

endmodule

//--- mul_unit.sv
module mul_unit (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            i_start,
    input  exec_pkg::xlen_t i_a,
    input  exec_pkg::xlen_t i_b,
    output logic            o_idle,
    output logic            o_valid,
    output exec_pkg::xlen_t o_data
);
    import exec_pkg::*;

    logic  busy_q;
    logic  valid_q;
    xlen_t acc_q;
    xlen_t mcand_q;
    xlen_t mplier_q;

    assign o_idle  = !busy_q;
    assign o_valid = valid_q;
    assign o_data  = acc_q;

    // Result stays valid until the next start
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else if (i_start) begin
            busy_q  <= 1'b1;
            valid_q <= 1'b0;
        end else if (busy_q && mplier_q[XLEN-1:1] == '0) begin
            // Early finish once no multiplier bits remain above this one
            busy_q  <= 1'b0;
            valid_q <= 1'b1;
        end
    end

    // One multiplier bit per cycle, low half of the product only
    always_ff @(posedge clk_i) begin
        if (i_start) begin
            acc_q    <= '0;
            mcand_q  <= i_a;
            mplier_q <= i_b;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

//--- operand_bypass.sv
module operand_bypass (
    input  exec_pkg::uop_t       i_uop,
    input  exec_pkg::xlen_t      i_rs1_data,
    input  exec_pkg::xlen_t      i_rs2_data,
    input  exec_pkg::stage_fwd_t i_ex1,
    input  exec_pkg::stage_fwd_t i_ex2,
    output exec_pkg::xlen_t      o_rs1,
    output exec_pkg::xlen_t      o_rs2,
    output logic                 o_stall
);
    import exec_pkg::*;

    // Lookup for one source, result is {stall, data}
    function automatic logic [XLEN:0] forward(reg_addr_t src, xlen_t rf_data,
                                             stage_fwd_t ex1, stage_fwd_t ex2);
        logic [XLEN:0] res;
        res = {1'b0, rf_data};
        if (src != '0) begin
            // EX1 holds the younger result and wins over EX2
            if (ex1.pending && ex1.rd == src) begin
                res = {!ex1.data_valid, ex1.data};
            end else if (ex2.pending && ex2.rd == src) begin
                res = {!ex2.data_valid, ex2.data};
            end
        end
        return res;
    endfunction

    logic [XLEN:0] src1;
    logic [XLEN:0] src2;

    assign src1 = forward(i_uop.rs1, i_rs1_data, i_ex1, i_ex2);
    assign src2 = forward(i_uop.rs2, i_rs2_data, i_ex1, i_ex2);

    assign o_rs1   = src1[XLEN-1:0];
    assign o_rs2   = src2[XLEN-1:0];
    // Either source waiting on an unfinished result holds the slot
    assign o_stall = src1[XLEN] || src2[XLEN];

endmodule

//--- reg_file.sv
module reg_file (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  exec_pkg::reg_addr_t i_rs1_addr,
    input  exec_pkg::reg_addr_t i_rs2_addr,
    input  logic                i_wr_en,
    input  exec_pkg::reg_addr_t i_wr_addr,
    input  exec_pkg::xlen_t     i_wr_data,
    output exec_pkg::xlen_t     o_rs1_data,
    output exec_pkg::xlen_t     o_rs2_data
);
    import exec_pkg::*;

    xlen_t regs_q [NUM_REGS];

    // Addresses arrive registered from the issue slot
    assign o_rs1_data = regs_q[i_rs1_addr];
    assign o_rs2_data = regs_q[i_rs2_addr];

    // x0 is never written and keeps its reset value of zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs_q[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

//--- result_pipe.sv
module result_pipe (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 i_issue,
    input  exec_pkg::func_unit_e i_unit,
    input  exec_pkg::reg_addr_t  i_rd,
    input  exec_pkg::xlen_t      i_pc,
    input  exec_pkg::xlen_t      i_alu_data,
    input  logic                 i_mul_valid,
    input  exec_pkg::xlen_t      i_mul_data,
    output logic                 o_ex1_ready,
    output exec_pkg::stage_fwd_t o_ex1,
    output exec_pkg::stage_fwd_t o_ex2,
    output logic                 o_wr_en,
    output exec_pkg::reg_addr_t  o_wr_addr,
    output exec_pkg::xlen_t      o_wr_data,
    output exec_pkg::commit_t    o_commit
);
    import exec_pkg::*;

    // Contents of one result stage
    typedef struct packed {
        logic       pending;
        func_unit_e unit;
        reg_addr_t  rd;
        xlen_t      pc;
        xlen_t      alu_data;
    } stage_t;

    stage_t ex1_q;
    stage_t ex1_d;
    stage_t ex1_fold;
    stage_t ex2_q;
    stage_t ex2_d;
    logic   ex1_valid;
    xlen_t  ex1_data;
    logic   ex2_valid;
    xlen_t  ex2_data;
    logic   ex2_ready;

    assign ex2_ready   = !ex2_q.pending || ex2_valid;
    assign o_ex1_ready = !ex1_q.pending || ex2_ready;

    ////////////////////
    // EX1 stage
    ////////////////////

    // While EX2 waits on the multiplier its valid belongs to EX2
    always_comb begin
        if (ex1_q.unit == FU_MUL) begin
            ex1_valid = i_mul_valid && ex2_q.unit != FU_MUL;
            ex1_data  = i_mul_data;
        end else begin
            ex1_valid = 1'b1;
            ex1_data  = ex1_q.alu_data;
        end
    end

    // Finished multiplier data is captured as ALU data
    always_comb begin
        ex1_fold = ex1_q;
        if (ex1_valid) begin
            ex1_fold.unit     = FU_ALU;
            ex1_fold.alu_data = ex1_data;
        end
    end

    always_comb begin
        ex1_d = ex1_fold;
        if (ex2_ready) begin
            ex1_d.pending = 1'b0;
            ex1_d.unit    = FU_ALU;
        end
        if (i_issue) begin
            ex1_d.pending  = 1'b1;
            ex1_d.unit     = i_unit;
            ex1_d.rd       = i_rd;
            ex1_d.pc       = i_pc;
            ex1_d.alu_data = i_alu_data;
        end
    end

    ////////////////////
    // EX2 stage
    ////////////////////

    always_comb begin
        if (ex2_q.unit == FU_MUL) begin
            ex2_valid = i_mul_valid;
            ex2_data  = i_mul_data;
        end else begin
            ex2_valid = 1'b1;
            ex2_data  = ex2_q.alu_data;
        end
    end

    always_comb begin
        ex2_d = ex2_q;
        // Commit empties the stage
        if (ex2_valid) begin
            ex2_d.pending = 1'b0;
            ex2_d.unit    = FU_ALU;
        end
        if (ex1_q.pending && ex2_ready) begin
            ex2_d = ex1_fold;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_q <= '0;
            ex2_q <= '0;
        end else begin
            ex1_q <= ex1_d;
            ex2_q <= ex2_d;
        end
    end

    assign o_ex1 = '{pending: ex1_q.pending, rd: ex1_q.rd,
                     data_valid: ex1_valid, data: ex1_data};
    assign o_ex2 = '{pending: ex2_q.pending, rd: ex2_q.rd,
                     data_valid: ex2_valid, data: ex2_data};

    // Write back and retire report
    assign o_wr_en   = ex2_q.pending && ex2_valid;
    assign o_wr_addr = ex2_q.rd;
    assign o_wr_data = ex2_data;
    assign o_commit  = '{valid: o_wr_en, rd: ex2_q.rd, data: ex2_data, pc: ex2_q.pc};

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk
);

    // Period of 10, first rising edge at time 5
    initial begin
        o_clk = 1'b0;
        forever begin
            #5 o_clk = ~o_clk;
        end
    end

endmodule

//--- tb_exec_core.sv
module tb_exec_core;
    import exec_pkg::*;

    // One expected retirement
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
        xlen_t     pc;
    } exp_commit_t;

    logic      clk;
    logic      rst_n;
    logic      uop_valid;
    uop_t      uop;
    logic      uop_ready;
    redirect_t redirect;
    commit_t   commit;

    // Reference model state
    xlen_t       model_regs [NUM_REGS];
    xlen_t       model_pc;
    logic        model_mispredict;
    exp_commit_t exp_commits [$];
    xlen_t       exp_redirects [$];
    int unsigned last_wait;
    int unsigned rand_seed;
    logic        result_reported;

    tb_clock_gen u_clock_gen (
        .o_clk (clk)
    );

    exec_core i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .i_uop_valid (uop_valid),
        .i_uop       (uop),
        .o_uop_ready (uop_ready),
        .o_redirect  (redirect),
        .o_commit    (commit)
    );

    bind exec_control exec_core_assertions u_assertions (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .i_handshake      (i_valid && o_ready),
        .i_state          (state_q),
        .i_redirect_valid (o_redirect.valid),
        .i_redirect_pc    (o_redirect.pc),
        .i_issue          (o_issue),
        .i_pc             (i_uop.pc)
    );

    ////////////////////
    // Checking helpers
    ////////////////////

    task automatic fail_stop(input string msg);
        result_reported = 1'b1;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] time %0t: %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic xlen_t model_alu(uop_t u, xlen_t a, xlen_t r2);
        xlen_t b;
        b = u.use_imm ? u.imm : r2;
        case (u.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            // Product of the two registers, low word
            OP_MUL:  return a * r2;
            // Branches and jumps leave the link address
            default: return u.pc + 32'd4;
        endcase
    endfunction

    function automatic logic branch_taken(uop_t u, xlen_t a, xlen_t b);
        case (u.op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_JAL:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Issue or drop, as the control stage will decide
    task automatic model_step(input uop_t u);
        xlen_t       a;
        xlen_t       b;
        exp_commit_t entry;
        if (u.pc == model_pc) begin
            a = model_regs[u.rs1];
            b = model_regs[u.rs2];
            entry.rd   = u.rd;
            entry.pc   = u.pc;
            entry.data = model_alu(u, a, b);
            exp_commits.push_back(entry);
            if (u.rd != 5'd0) begin
                model_regs[u.rd] = entry.data;
            end
            model_pc = branch_taken(u, a, b) ? u.pc + u.imm : u.pc + 32'd4;
            model_mispredict = 1'b0;
        end else if (!model_mispredict) begin
            exp_redirects.push_back(model_pc);
            model_mispredict = 1'b1;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic uop_t make_uop(xlen_t pc, uop_op_e op, reg_addr_t rd, reg_addr_t rs1,
                                      reg_addr_t rs2, logic use_imm, xlen_t imm);
        uop_t u;
        u.pc      = pc;
        u.op      = op;
        u.rd      = rd;
        u.rs1     = rs1;
        u.rs2     = rs2;
        u.use_imm = use_imm;
        u.imm     = imm;
        return u;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_uop(input uop_t u);
        int unsigned waited;
        logic        accepted;
        model_step(u);
        uop_valid = 1'b1;
        uop       = u;
        waited    = 0;
        accepted  = 1'b0;
        while (!accepted && waited < 200) begin
            // Ready comes from registered state only
            accepted = uop_ready;
            @(negedge clk);
            waited++;
        end
        if (!accepted) begin
            fail_stop("input handshake did not complete within 200 cycles");
        end
        last_wait = waited;
        uop_valid = 1'b0;
    endtask

    task automatic send_imm(input uop_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input xlen_t imm);
        send_uop(make_uop(model_pc, op, rd, rs1, 5'd0, 1'b1, imm));
    endtask

    task automatic send_reg(input uop_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2);
        send_uop(make_uop(model_pc, op, rd, rs1, rs2, 1'b0, 32'd0));
    endtask

    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        while ((exp_commits.size() != 0 || exp_redirects.size() != 0) && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (exp_commits.size() != 0 || exp_redirects.size() != 0) begin
            fail_stop("expected commits or redirects missing after 200 cycles");
        end
    endtask

    ////////////////////
    // Output monitors
    ////////////////////

    always @(negedge clk) begin : commit_monitor
        exp_commit_t expected;
        if (rst_n && commit.valid) begin
            if (exp_commits.size() == 0) begin
                fail_stop($sformatf("unexpected commit from pc 0x%08h at time %0t",
                                    commit.pc, $time));
            end else begin
                expected = exp_commits.pop_front();
                check_value("o_commit.pc", commit.pc, expected.pc);
                check_value("o_commit.rd", xlen_t'(commit.rd), xlen_t'(expected.rd));
                check_value("o_commit.data", commit.data, expected.data);
            end
        end
    end

    always @(negedge clk) begin : redirect_monitor
        if (rst_n && redirect.valid) begin
            if (exp_redirects.size() == 0) begin
                fail_stop($sformatf("unexpected redirect to 0x%08h at time %0t",
                                    redirect.pc, $time));
            end else begin
                check_value("o_redirect.pc", redirect.pc, exp_redirects.pop_front());
            end
        end
    end

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic reset_idle();
        repeat (10) begin
            @(negedge clk);
            check_value("o_uop_ready", xlen_t'(uop_ready), 32'd1);
            check_value("o_redirect.valid", xlen_t'(redirect.valid), 32'd0);
            check_value("o_commit.valid", xlen_t'(commit.valid), 32'd0);
        end
    endtask

    task automatic independent_alu();
        send_imm(OP_ADD, 5'd1, 5'd0, 32'h1234_5678);
        send_imm(OP_OR, 5'd2, 5'd0, 32'hffff_ff80);
        send_imm(OP_XOR, 5'd3, 5'd0, 32'h0000_0005);
        send_imm(OP_SUB, 5'd4, 5'd0, 32'h0000_0100);
        send_imm(OP_ADD, 5'd0, 5'd0, 32'h0000_dead);
        wait_drain();
        send_reg(OP_AND, 5'd5, 5'd1, 5'd2);
        send_reg(OP_SLL, 5'd6, 5'd1, 5'd3);
        send_reg(OP_SRL, 5'd7, 5'd2, 5'd3);
        send_imm(OP_SRA, 5'd8, 5'd2, 32'd3);
        send_reg(OP_SLT, 5'd9, 5'd2, 5'd1);
        send_reg(OP_SLTU, 5'd10, 5'd2, 5'd1);
        send_imm(OP_SLTU, 5'd11, 5'd3, 32'd6);
        wait_drain();
        // x0 still reads zero after the write above
        send_reg(OP_ADD, 5'd12, 5'd0, 5'd0);
        wait_drain();
    endtask

    task automatic dependent_chain();
        send_imm(OP_ADD, 5'd13, 5'd1, 32'd1);
        send_reg(OP_ADD, 5'd14, 5'd13, 5'd13);
        send_reg(OP_SUB, 5'd15, 5'd14, 5'd13);
        send_reg(OP_XOR, 5'd16, 5'd15, 5'd14);
        send_imm(OP_SRA, 5'd16, 5'd16, 32'd2);
        send_reg(OP_OR, 5'd17, 5'd16, 5'd15);
        wait_drain();
    endtask

    task automatic mul_then_add();
        xlen_t       a;
        xlen_t       b;
        int unsigned iter;
        for (iter = 0; iter < 5; iter++) begin
            a = $urandom;
            // Last round uses a short multiplier for the early finish
            b = (iter == 4) ? ($urandom % 8) : $urandom;
            send_imm(OP_ADD, 5'd18, 5'd0, a);
            send_imm(OP_ADD, 5'd19, 5'd0, b);
            send_reg(OP_MUL, 5'd20, 5'd18, 5'd19);
            send_reg(OP_ADD, 5'd21, 5'd20, 5'd18);
            send_imm(OP_ADD, 5'd22, 5'd0, xlen_t'(iter));
            check_value("o_uop_ready held low behind dependent add",
                        xlen_t'(last_wait > 1), 32'd1);
            wait_drain();
        end
    endtask

    task automatic branch_redirect();
        xlen_t branch_pc;
        send_imm(OP_ADD, 5'd5, 5'd0, 32'd77);
        branch_pc = model_pc;
        send_uop(make_uop(branch_pc, OP_BEQ, 5'd0, 5'd5, 5'd5, 1'b0, 32'h40));
        // Fall-through path the front end fetched before the redirect
        send_uop(make_uop(branch_pc + 32'd4, OP_ADD, 5'd5, 5'd0, 5'd0, 1'b1, 32'd1));
        send_uop(make_uop(branch_pc + 32'd8, OP_ADD, 5'd6, 5'd0, 5'd0, 1'b1, 32'd2));
        send_imm(OP_ADD, 5'd6, 5'd5, 32'd1);
        send_reg(OP_BNE, 5'd0, 5'd5, 5'd5);
        send_uop(make_uop(model_pc, OP_JAL, 5'd1, 5'd0, 5'd0, 1'b0, 32'h20));
        send_imm(OP_ADD, 5'd7, 5'd1, 32'd0);
        wait_drain();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst_n            = 1'b0;
        uop_valid        = 1'b0;
        uop              = '0;
        rand_seed        = 32'h8dd5;
        result_reported  = 1'b0;
        last_wait        = 0;
        model_pc         = RESET_PC;
        model_mispredict = 1'b0;
        model_regs       = '{default: '0};
        void'($urandom(rand_seed));

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        reset_idle();
        independent_alu();
        dependent_chain();
        mul_then_add();
        branch_redirect();

        if (exp_commits.size() != 0 || exp_redirects.size() != 0) begin
            fail_stop("expected commits or redirects left over at end of run");
        end else begin
            result_reported = 1'b1;
            $display("STATUS: PASS");
            $finish;
        end
    end

    final begin
        if (!result_reported) begin
            $display("STATUS: FAIL");
        end
    end

endmodule
